// File: source/mem_pkg.sv
/* memory data path shared constants */

package mem_pkg;

    // ------------------------------------------------------------------------
    // cpu side widths
    localparam int addr_w      = 32;             // byte address
    localparam int word_addr_w = 30;             // avalon address bits 31..2
    localparam int read_len_w  = 4;              // read_length, 1 to 8 bytes
    localparam int write_len_w = 3;              // write_length, 1 to 4 bytes
    localparam int read_w      = 64;             // read_data

    // ------------------------------------------------------------------------
    // bus side widths
    localparam int bus_w       = 32;             // avalon data word
    localparam int bus_bytes   = bus_w / 8;      // lanes per word
    localparam int burst_w     = 4;              // avm_burstcount

    // ------------------------------------------------------------------------
    // request span, worst case is 8 bytes starting at offset 3
    localparam int max_beats   = 3;              // words one request can touch
    localparam int lane_bytes  = max_beats * bus_bytes;  // 12 lanes
    localparam int lane_w      = lane_bytes * 8;          // 96 bits
    localparam int beats_w     = 2;              // holds 1..max_beats

endpackage

// File: source/mem_link_if.sv
/* four-phase request link */

interface mem_link_if;
    import mem_pkg::*;

    logic                   req;         // master request, level
    logic                   ack;         // slave acknowledge, level
    logic                   write;       // 1 write, 0 read
    logic [word_addr_w-1:0] address;     // first word of the span
    logic [beats_w-1:0]     beats;       // words in the span, 1..3
    logic [lane_bytes-1:0]  byteenable;  // one bit per byte lane
    logic [lane_w-1:0]      writedata;   // lanes already aligned
    logic [lane_w-1:0]      readdata;    // raw words, lane 0 first

    // request side
    modport master (
        output req, write, address, beats, byteenable, writedata,
        input  ack, readdata
    );

    // serving side
    modport slave (
        input  req, write, address, beats, byteenable, writedata,
        output ack, readdata
    );

endinterface

// File: source/mem_request.sv
/* read/write request formatter */

module mem_request (
    input  logic                            clk,
    input  logic                            rst_n,

    input  logic                            read_do,
    input  logic [mem_pkg::addr_w-1:0]      read_address,
    input  logic [mem_pkg::read_len_w-1:0]  read_length,
    output logic                            read_done,
    output logic [mem_pkg::read_w-1:0]      read_data,

    input  logic                            write_do,
    input  logic [mem_pkg::addr_w-1:0]      write_address,
    input  logic [mem_pkg::write_len_w-1:0] write_length,
    input  logic [mem_pkg::bus_w-1:0]       write_data,
    output logic                            write_done,

    mem_link_if.master                      link
);
    import mem_pkg::*;

    logic [addr_w-1:0]     sel_address;  // address of the winning request
    logic [read_len_w-1:0] sel_length;   // length, writes zero extended
    logic [3:0]            span;         // offset + length rounded up
    logic [lane_bytes-1:0] len_mask;     // length ones, unshifted
    logic                  accept;       // take a new do this cycle
    logic                  complete;     // ack seen while req still up

    logic [1:0]            offset;       // byte offset in the first word
    logic [read_len_w-1:0] length;       // kept for the result mask
    logic [lane_w-1:0]     shifted;      // readdata moved down to lane 0
    logic [read_w-1:0]     extracted;    // shifted with tail bytes cleared

    // ------------------------------------------------------------------------
    // arbitration and formatting

    // write wins, so a read of the same bytes waits for the new data
    assign sel_address = write_do ? write_address : read_address;
    assign sel_length  = write_do ? read_len_w'(write_length) : read_length;

    // idle only once the previous handshake is fully closed
    assign accept   = (read_do || write_do) && !link.req && !link.ack
                      && !read_done && !write_done;
    assign complete = link.req && link.ack;

    assign span     = 4'(sel_address[1:0]) + 4'(sel_length) + 4'd3;  // ceil in bits 3..2
    assign len_mask = (lane_bytes'(1) << sel_length) - lane_bytes'(1);

    // ------------------------------------------------------------------------
    // result extraction

    assign shifted = link.readdata >> {offset, 3'b000};

    always_comb begin
        for (int i = 0; i < read_w / 8; i++) begin
            // bytes past read_length read as zero
            extracted[i*8 +: 8] = (i < length) ? shifted[i*8 +: 8] : 8'h00;
        end
    end

    // ------------------------------------------------------------------------
    // handshake control

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            link.req   <= 1'b0;
            read_done  <= 1'b0;
            write_done <= 1'b0;
        end else begin
            read_done  <= 1'b0;                  // done is a single pulse
            write_done <= 1'b0;
            if (accept) begin
                link.req <= 1'b1;                // cycle after the do
            end else if (complete) begin
                link.req   <= 1'b0;              // phase 3
                read_done  <= !link.write;
                write_done <= link.write;
            end
        end
    end

    // payload, held from accept until the next accept
    always_ff @(posedge clk) begin
        if (accept) begin
            link.write      <= write_do;
            link.address    <= sel_address[addr_w-1:2];
            link.beats      <= span[3:2];        // 1..3 words
            link.byteenable <= len_mask << sel_address[1:0];
            link.writedata  <= lane_w'(write_data) << {sel_address[1:0], 3'b000};
            offset          <= sel_address[1:0];
            length          <= sel_length;
        end
        if (complete && !link.write) begin
            read_data <= extracted;              // valid with read_done
        end
    end

endmodule

// File: source/mem_link.sv
/* registered link slice */

module mem_link (
    input  logic       clk,
    input  logic       rst_n,
    mem_link_if.slave  up,
    mem_link_if.master down
);
    import mem_pkg::*;

    logic              wait_fall;   // down req dropped, waiting for ack low
    logic              idle;        // no handshake on either side
    logic [lane_w-1:0] read_hold;   // words returned from below

    // one-hot progress, the three flags never overlap
    assign idle = !down.req && !wait_fall && !up.ack;

    assign up.readdata = read_hold;

    // ------------------------------------------------------------------------
    // sequencing, downstream handshake closes before upstream ack rises

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            down.req  <= 1'b0;
            wait_fall <= 1'b0;
            up.ack    <= 1'b0;
        end else begin
            if (idle && up.req) begin
                down.req <= 1'b1;                // one cycle after up req
            end else if (down.req && down.ack) begin
                down.req  <= 1'b0;
                wait_fall <= 1'b1;
            end else if (wait_fall && !down.ack) begin
                wait_fall <= 1'b0;
                up.ack    <= 1'b1;               // one cycle after down ack falls
            end else if (up.ack && !up.req) begin
                up.ack <= 1'b0;                  // back to idle
            end
        end
    end

    // ------------------------------------------------------------------------
    // payload registers

    always_ff @(posedge clk) begin
        if (idle && up.req) begin
            down.write      <= up.write;
            down.address    <= up.address;
            down.beats      <= up.beats;
            down.byteenable <= up.byteenable;
            down.writedata  <= up.writedata;
        end
        if (down.req && down.ack) begin
            read_hold <= down.readdata;          // kept until up side closes
        end
    end

endmodule

// File: source/avalon_burst.sv
/* avalon master burst engine */

module avalon_burst (
    input  logic                             clk,
    input  logic                             rst_n,

    mem_link_if.slave                        link,

    output logic [mem_pkg::word_addr_w-1:0]  avm_address,
    output logic [mem_pkg::bus_w-1:0]        avm_writedata,
    output logic [mem_pkg::bus_bytes-1:0]    avm_byteenable,
    output logic [mem_pkg::burst_w-1:0]      avm_burstcount,
    output logic                             avm_write,
    output logic                             avm_read,
    input  logic                             avm_waitrequest,
    input  logic                             avm_readdatavalid,
    input  logic [mem_pkg::bus_w-1:0]        avm_readdata
);
    import mem_pkg::*;

    logic [beats_w-1:0] beat;        // current word of the burst
    logic               collect;     // read command taken, data pending
    logic               last_beat;   // beat is the final word
    logic               start;       // new request from the link
    logic               read_word;   // a read data beat lands this cycle

    assign last_beat = (beat == beats_w'(link.beats - 1'b1));
    assign start     = link.req && !link.ack && !avm_write && !avm_read && !collect;
    assign read_word = collect && avm_readdatavalid;

    // ------------------------------------------------------------------------
    // bus command, all fields held by the link until ack falls

    assign avm_address    = link.address;              // burst start word
    assign avm_burstcount = burst_w'(link.beats);
    assign avm_writedata  = link.writedata[beat*bus_w +: bus_w];

    // reads fetch whole words, lanes are picked out upstream
    assign avm_byteenable = avm_read ? {bus_bytes{1'b1}}
                                     : link.byteenable[beat*bus_bytes +: bus_bytes];

    // ------------------------------------------------------------------------
    // burst sequencer

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            avm_write <= 1'b0;
            avm_read  <= 1'b0;
            collect   <= 1'b0;
            link.ack  <= 1'b0;
            beat      <= '0;
        end else begin
            if (start) begin
                beat      <= '0;
                avm_write <= link.write;
                avm_read  <= !link.write;
            end else if (avm_write && !avm_waitrequest) begin
                if (last_beat) begin
                    avm_write <= 1'b0;
                    link.ack  <= 1'b1;           // last write beat accepted
                end else begin
                    beat <= beat + 1'b1;
                end
            end else if (avm_read && !avm_waitrequest) begin
                avm_read <= 1'b0;                // single command per burst
                collect  <= 1'b1;
            end else if (read_word) begin
                if (last_beat) begin
                    collect  <= 1'b0;
                    link.ack <= 1'b1;            // last read word in
                end else begin
                    beat <= beat + 1'b1;
                end
            end else if (link.ack && !link.req) begin
                link.ack <= 1'b0;                // phase 4
            end
        end
    end

    // returned words, lane 0 word first
    always_ff @(posedge clk) begin
        if (read_word) begin
            link.readdata[beat*bus_w +: bus_w] <= avm_readdata;
        end
    end

endmodule

// File: source/memory_data.sv
/* cpu memory data path */

module memory_data (
    input  logic                             clk,
    input  logic                             rst_n,

    // ------------------------------------------------------------------------
    // cpu read port
    input  logic                             read_do,
    output logic                             read_done,
    input  logic [mem_pkg::addr_w-1:0]       read_address,
    input  logic [mem_pkg::read_len_w-1:0]   read_length,
    output logic [mem_pkg::read_w-1:0]       read_data,

    // ------------------------------------------------------------------------
    // cpu write port
    input  logic                             write_do,
    output logic                             write_done,
    input  logic [mem_pkg::addr_w-1:0]       write_address,
    input  logic [mem_pkg::write_len_w-1:0]  write_length,
    input  logic [mem_pkg::bus_w-1:0]        write_data,

    // ------------------------------------------------------------------------
    // avalon master
    output logic [mem_pkg::word_addr_w-1:0]  avm_address,
    output logic [mem_pkg::bus_w-1:0]        avm_writedata,
    output logic [mem_pkg::bus_bytes-1:0]    avm_byteenable,
    output logic [mem_pkg::burst_w-1:0]      avm_burstcount,
    output logic                             avm_write,
    output logic                             avm_read,
    input  logic                             avm_waitrequest,
    input  logic                             avm_readdatavalid,
    input  logic [mem_pkg::bus_w-1:0]        avm_readdata
);

    mem_link_if link_up ();      // request side to slice
    mem_link_if link_down ();    // slice to bus side

    mem_request mem_request_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .read_do        (read_do),
        .read_address   (read_address),
        .read_length    (read_length),
        .read_done      (read_done),
        .read_data      (read_data),
        .write_do       (write_do),
        .write_address  (write_address),
        .write_length   (write_length),
        .write_data     (write_data),
        .write_done     (write_done),
        .link           (link_up.master)
    );

    mem_link mem_link_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .up             (link_up.slave),
        .down           (link_down.master)
    );

    avalon_burst avalon_burst_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .link               (link_down.slave),
        .avm_address        (avm_address),
        .avm_writedata      (avm_writedata),
        .avm_byteenable     (avm_byteenable),
        .avm_burstcount     (avm_burstcount),
        .avm_write          (avm_write),
        .avm_read           (avm_read),
        .avm_waitrequest    (avm_waitrequest),
        .avm_readdatavalid  (avm_readdatavalid),
        .avm_readdata       (avm_readdata)
    );

endmodule

// File: dv/tb_clock.sv
/* testbench clock and reset */

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;                   // period 10
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);               // three reset cycles
        rst_n <= 1'b1;
    end

endmodule

// File: dv/memory_data_assertions.sv
/* avalon and done protocol checks */

module memory_data_assertions (
    input logic                            clk,
    input logic                            rst_n,
    input logic                            read_done,
    input logic                            write_done,
    input logic [mem_pkg::word_addr_w-1:0] avm_address,
    input logic [mem_pkg::bus_w-1:0]       avm_writedata,
    input logic [mem_pkg::bus_bytes-1:0]   avm_byteenable,
    input logic [mem_pkg::burst_w-1:0]     avm_burstcount,
    input logic                            avm_write,
    input logic                            avm_read,
    input logic                            avm_waitrequest
);

    int violation_count = 0;                     // read back by the testbench

    // ------------------------------------------------------------------------
    // avalon master side

    hold_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        (avm_read || avm_write) && avm_waitrequest |=>
            $stable({avm_read, avm_write, avm_address, avm_burstcount,
                     avm_byteenable, avm_writedata}))
        else begin
            $error("avalon command changed while waitrequest was high");
            violation_count++;
        end

    one_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        !(avm_read && avm_write))
        else begin
            $error("avm_read and avm_write high together");
            violation_count++;
        end

    // ------------------------------------------------------------------------
    // cpu side done pulses

    done_apart: assert property (@(posedge clk) disable iff (!rst_n)
        !(read_done && write_done))
        else begin
            $error("read_done and write_done in the same cycle");
            violation_count++;
        end

    read_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        read_done |=> !read_done)
        else begin
            $error("read_done longer than one cycle");
            violation_count++;
        end

    write_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        write_done |=> !write_done)
        else begin
            $error("write_done longer than one cycle");
            violation_count++;
        end

endmodule

// File: dv/memory_data_tb.sv
/* memory data path testbench */

module memory_data_tb;
    import mem_pkg::*;

    localparam int num_random   = 300;
    localparam int num_requests = 32 + 32 + 8 + num_random;  // sizes the watchdog

    logic                   clk;
    logic                   rst_n;
    logic                   read_do;
    logic                   read_done;
    logic [addr_w-1:0]      read_address;
    logic [read_len_w-1:0]  read_length;
    logic [read_w-1:0]      read_data;
    logic                   write_do;
    logic                   write_done;
    logic [addr_w-1:0]      write_address;
    logic [write_len_w-1:0] write_length;
    logic [bus_w-1:0]       write_data;
    logic [word_addr_w-1:0] avm_address;
    logic [bus_w-1:0]       avm_writedata;
    logic [bus_bytes-1:0]   avm_byteenable;
    logic [burst_w-1:0]     avm_burstcount;
    logic                   avm_write;
    logic                   avm_read;
    logic                   avm_waitrequest = 1'b0;    // bus idle until the model runs
    logic                   avm_readdatavalid = 1'b0;
    logic [bus_w-1:0]       avm_readdata = '0;

    logic [7:0]             mem [256];           // avalon memory model
    logic [7:0]             shadow [256];        // bytes as the cpu expects them
    logic [word_addr_w-1:0] read_queue [$];      // words still owed to the DUT
    logic [31:0]            gap_state = 32'h73a; // bus gap generator
    logic [31:0]            stim_state = 32'h73a;
    int                     issued_count = 0;
    int                     done_count = 0;
    int                     wr_beat = 0;         // beat within the write burst

    tb_clock clock_gen (.clk(clk), .rst_n(rst_n));
    memory_data UUT (.*);
    bind memory_data memory_data_assertions assertions_inst (.*);

    // ------------------------------------------------------------------------
    // helpers and reference model

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // shadow bytes from address upward, zero above length
    function automatic logic [read_w-1:0] expected_read(input logic [addr_w-1:0] a,
                                                        input logic [read_len_w-1:0] n);
        logic [read_w-1:0] r;
        r = '0;
        for (int i = 0; i < read_w / 8; i++) begin
            if (i < n) r[i*8 +: 8] = shadow[8'(a + i)];
        end
        return r;
    endfunction

    function automatic logic [burst_w-1:0] expected_beats(input logic [addr_w-1:0] a,
                                                          input int n);
        return burst_w'(((a + n - 1) >> 2) - (a >> 2) + 1);  // first to last word
    endfunction

    function automatic logic [bus_bytes-1:0] expected_enables(input logic [addr_w-1:0] a,
                                                              input int n, input int beat);
        logic [bus_bytes-1:0] e;
        logic [addr_w-1:0]    b;
        for (int j = 0; j < bus_bytes; j++) begin
            b    = {a[addr_w-1:2], 2'b00} + beat * bus_bytes + j;
            e[j] = (b >= a) && (b < a + n);      // byte inside the request
        end
        return e;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_read_data(input logic [read_w-1:0] expected, actual);
        if (actual !== expected)
            abort_run($sformatf("[ERROR] %0t read_data expected %h actual %h",
                                $time, expected, actual));
    endtask

    task automatic check_burst(input logic [burst_w-1:0] expected, actual);
        if (actual !== expected)
            abort_run($sformatf("[ERROR] %0t avm_burstcount expected %h actual %h",
                                $time, expected, actual));
    endtask

    task automatic check_byteenable(input logic [bus_bytes-1:0] expected, actual);
        if (actual !== expected)
            abort_run($sformatf("[ERROR] %0t avm_byteenable expected %h actual %h",
                                $time, expected, actual));
    endtask

    // ------------------------------------------------------------------------
    // avalon memory model with random waitrequest and readdatavalid gaps

    always @(posedge clk) begin
        logic [word_addr_w-1:0] word_addr;
        logic [bus_w-1:0]       word_data;
        gap_state = xorshift(gap_state);
        if (!rst_n) begin
            avm_waitrequest   <= 1'b0;
            avm_readdatavalid <= 1'b0;
            wr_beat = 0;
            read_queue.delete();
        end else begin
            if (avm_write && !avm_waitrequest) begin
                if (wr_beat == 0)
                    check_burst(expected_beats(write_address, write_length), avm_burstcount);
                check_byteenable(expected_enables(write_address, write_length, wr_beat),
                                 avm_byteenable);
                for (int j = 0; j < bus_bytes; j++) begin
                    if (avm_byteenable[j])
                        mem[8'({avm_address, 2'b00} + wr_beat * 4 + j)] = avm_writedata[j*8 +: 8];
                end
                wr_beat = (wr_beat + 1 == avm_burstcount) ? 0 : wr_beat + 1;
            end
            if (avm_read && !avm_waitrequest) begin
                check_burst(expected_beats(read_address, read_length), avm_burstcount);
                for (int k = 0; k < avm_burstcount; k++) begin
                    read_queue.push_back(avm_address + k);
                end
            end
            if (read_queue.size() > 0 && gap_state[3:2] != 2'b00) begin
                word_addr = read_queue.pop_front();
                for (int j = 0; j < bus_bytes; j++) begin
                    word_data[j*8 +: 8] = mem[8'({word_addr, 2'b00} + j)];
                end
                avm_readdata      <= word_data;
                avm_readdatavalid <= 1'b1;
            end else begin
                avm_readdatavalid <= 1'b0;       // gap or nothing owed
            end
            avm_waitrequest <= (gap_state[1:0] == 2'b00);
        end
    end

    // ------------------------------------------------------------------------
    // compare process, do and fields are still held in the done cycle

    always @(posedge clk) begin
        if (rst_n) begin
            if (write_done) begin
                if (!write_do) abort_run("write_done arrived with no write pending");
                for (int i = 0; i < write_length; i++) begin
                    shadow[8'(write_address + i)] = write_data[i*8 +: 8];
                end
                done_count++;
            end
            if (read_done) begin
                if (!read_do) abort_run("read_done arrived with no read pending");
                if (write_do) abort_run("read finished ahead of the pending write");
                check_read_data(expected_read(read_address, read_length), read_data);
                done_count++;
            end
        end
    end

    // ------------------------------------------------------------------------
    // stimulus

    task automatic issue_read(input logic [addr_w-1:0] a, input logic [read_len_w-1:0] n);
        @(posedge clk);
        read_address <= a;
        read_length  <= n;
        read_do      <= 1'b1;
        issued_count++;
        do @(posedge clk); while (read_done !== 1'b1);
        read_do <= 1'b0;                         // dropped in the done cycle
    endtask

    task automatic issue_write(input logic [addr_w-1:0] a, input logic [write_len_w-1:0] n,
                               input logic [bus_w-1:0] d);
        @(posedge clk);
        write_address <= a;
        write_length  <= n;
        write_data    <= d;
        write_do      <= 1'b1;
        issued_count++;
        do @(posedge clk); while (write_done !== 1'b1);
        write_do <= 1'b0;
    endtask

    // both do lines in one cycle, write must finish first
    task automatic issue_pair(input logic [addr_w-1:0] wa, input logic [write_len_w-1:0] wn,
                              input logic [addr_w-1:0] ra, input logic [read_len_w-1:0] rn);
        @(posedge clk);
        stim_state = xorshift(stim_state);
        write_address <= wa;
        write_length  <= wn;
        write_data    <= stim_state;
        write_do      <= 1'b1;
        read_address  <= ra;
        read_length   <= rn;
        read_do       <= 1'b1;
        issued_count += 2;
        do @(posedge clk); while (write_done !== 1'b1);
        write_do <= 1'b0;
        do @(posedge clk); while (read_done !== 1'b1);
        read_do <= 1'b0;
    endtask

    initial begin
        logic [31:0] r;
        read_do       = 1'b0;
        read_address  = '0;
        read_length   = 4'd1;
        write_do      = 1'b0;
        write_address = '0;
        write_length  = 3'd1;
        write_data    = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i]    = 8'(i * 37 + 11);         // every address its own byte
            shadow[i] = mem[i];
        end
        wait (rst_n === 1'b1);
        repeat (8) begin
            @(posedge clk);
            if ({read_done, write_done, avm_read, avm_write} !== 4'b0000)
                abort_run("DUT left idle after reset with no request");
        end
        for (int n = 1; n <= 8; n++) begin
            for (int off = 0; off < 4; off++) issue_read(32'h40 + n * 8 + off, 4'(n));
        end
        for (int n = 1; n <= 4; n++) begin
            for (int off = 0; off < 4; off++) begin
                stim_state = xorshift(stim_state);
                issue_write(32'h80 + ((n - 1) * 4 + off) * 8 + off, 3'(n), stim_state);
                issue_read(32'h80 + ((n - 1) * 4 + off) * 8, 4'd8);  // both words around it
            end
        end
        issue_pair(32'hc1, 3'd4, 32'hc0, 4'd8);
        issue_pair(32'hc6, 3'd2, 32'hc4, 4'd5);
        issue_pair(32'hcb, 3'd1, 32'hcb, 4'd1);
        issue_pair(32'hcd, 3'd3, 32'hcc, 4'd8);
        repeat (num_random) begin
            stim_state = xorshift(stim_state);
            r          = stim_state;
            stim_state = xorshift(stim_state);
            if (r[8]) issue_write({24'h0, r[7:0]}, 3'(r[10:9]) + 3'd1, stim_state);
            else issue_read({24'h0, r[7:0]}, 4'(r[11:9]) + 4'd1);
        end
        repeat (4) @(posedge clk);
        if (done_count != issued_count)
            abort_run($sformatf("%0d requests issued but %0d done pulses seen",
                                issued_count, done_count));
        else if (UUT.assertions_inst.violation_count != 0)
            abort_run("protocol assertions reported violations");
        else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

    // watchdog
    initial begin
        repeat (num_requests * 64 + 32) @(posedge clk);
        abort_run("watchdog expired before all requests completed");
    end

endmodule

// File: project.f
source/mem_pkg.sv
source/mem_link_if.sv
source/mem_request.sv
source/mem_link.sv
source/avalon_burst.sv
source/memory_data.sv
dv/tb_clock.sv
dv/memory_data_assertions.sv
dv/memory_data_tb.sv
